// ==== design/excp_pkg.sv ====
package excp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;        // address or data word.
    typedef logic [4:0]  exccode_t;     // cause.exccode.
    typedef logic [4:0]  cp0_addr_t;    // cp0 register number.

    // exception codes
    localparam exccode_t EXC_INT  = 5'd0;
    localparam exccode_t EXC_ADEL = 5'd4;
    localparam exccode_t EXC_ADES = 5'd5;
    localparam exccode_t EXC_SYS  = 5'd8;
    localparam exccode_t EXC_BP   = 5'd9;
    localparam exccode_t EXC_RI   = 5'd10;
    localparam exccode_t EXC_OV   = 5'd12;

    // cp0 register map
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    localparam word_t EXC_VECTOR = 32'hbfc0_0380;    // general exception entry.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic data_adel;
        logic data_ades;
        logic overflow;
        logic ri;
    } excp_flags_t;

    typedef struct packed {
        word_t       pc;
        word_t       badvaddr;        // faulting data address.
        logic        in_ds;           // instruction sits in a branch delay slot.
        excp_flags_t flags;
    } slot_info_t;

    typedef struct packed {
        logic     update;             // exception commit, sets exl.
        exccode_t exccode;
        logic     bd;
        word_t    epc;
        logic     badvaddr_ena;
        word_t    badvaddr;
        logic     cls_exl;            // eret.
    } cp0_upd_t;

endpackage

// ==== design/exception_ctrl.sv ====
`timescale 1ns/1ps

module exception_ctrl (
    input  excp_pkg::slot_info_t slot_1,
    input  excp_pkg::slot_info_t slot_2,
    input  logic                 int_req,
    input  excp_pkg::word_t      epc,
    output logic                 redirect_en,
    output excp_pkg::word_t      redirect_pc,
    output logic                 flush,
    output excp_pkg::cp0_upd_t   upd
);
    import excp_pkg::*;

    logic has_1;
    logic has_2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-slot resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // common part of any exception taken on a slot.
    function automatic cp0_upd_t fault_base(input slot_info_t s);
        cp0_upd_t u;
        u        = '0;
        u.update = 1'b1;
        u.bd     = s.in_ds;
        u.epc    = s.in_ds ? s.pc - 32'd4 : s.pc;    // restart at the branch.
        return u;
    endfunction

    function automatic cp0_upd_t slot_commit(input slot_info_t s);
        cp0_upd_t u;
        u = fault_base(s);
        if (s.flags.inst_adel) begin
            u.exccode      = EXC_ADEL;
            u.badvaddr_ena = 1'b1;
            u.badvaddr     = s.pc;
        end else if (s.flags.ri) begin
            u.exccode = EXC_RI;
        end else if (s.flags.overflow) begin
            u.exccode = EXC_OV;
        end else if (s.flags.syscall) begin
            u.exccode = EXC_SYS;
        end else if (s.flags.brk) begin
            u.exccode = EXC_BP;
        end else if (s.flags.eret) begin
            u         = '0;                  // no cp0 commit on return.
            u.cls_exl = 1'b1;
        end else if (s.flags.data_adel) begin
            u.exccode      = EXC_ADEL;
            u.badvaddr_ena = 1'b1;
            u.badvaddr     = s.badvaddr;
        end else begin
            u.exccode      = EXC_ADES;       // only data_ades left.
            u.badvaddr_ena = 1'b1;
            u.badvaddr     = s.badvaddr;
        end
        return u;
    endfunction

    assign has_1 = |slot_1.flags;
    assign has_2 = |slot_2.flags;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        upd         = '0;
        redirect_en = 1'b0;
        if (int_req) begin
            // interrupts are charged to the older slot.
            upd         = fault_base(slot_1);
            upd.exccode = EXC_INT;
            redirect_en = 1'b1;
        end else if (has_1) begin
            upd         = slot_commit(slot_1);
            redirect_en = 1'b1;
        end else if (has_2) begin
            upd         = slot_commit(slot_2);
            redirect_en = 1'b1;
        end
    end

    always_comb begin
        if (!redirect_en) begin
            redirect_pc = '0;
        end else if (upd.cls_exl) begin
            redirect_pc = epc;               // eret.
        end else begin
            redirect_pc = EXC_VECTOR;
        end
    end

    assign flush = redirect_en;    // every redirect kills younger work.

endmodule

// ==== design/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            count_wr,
    input  logic            compare_wr,
    input  excp_pkg::word_t wdata,
    output excp_pkg::word_t count,
    output excp_pkg::word_t compare,
    output logic            timer_int
);

    logic half;    // count steps when this is set.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half  <= 1'b0;
            count <= '0;
        end else if (count_wr) begin
            half  <= 1'b0;
            count <= wdata;
        end else begin
            half <= ~half;
            if (half) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare   <= '0;
            timer_int <= 1'b0;
        end else if (compare_wr) begin
            compare   <= wdata;
            timer_int <= 1'b0;      // acknowledge.
        end else if (count == compare) begin
            timer_int <= 1'b1;      // sticky until compare is rewritten.
        end
    end

endmodule

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  excp_pkg::cp0_upd_t   upd,
    input  logic                 mtc0_en,
    input  excp_pkg::cp0_addr_t  mtc0_addr,
    input  excp_pkg::word_t      mtc0_data,
    input  excp_pkg::cp0_addr_t  mfc0_addr,
    output excp_pkg::word_t      mfc0_data,
    input  logic [5:0]           hw_int,
    output logic                 int_req,
    output excp_pkg::word_t      epc
);
    import excp_pkg::*;

    logic [7:0] status_im;
    logic       status_exl;
    logic       status_ie;
    logic       cause_bd;
    exccode_t   cause_exccode;
    logic [7:0] cause_ip;
    word_t      badvaddr;
    word_t      count;
    word_t      compare;
    logic       timer_int;
    logic       count_wr;
    logic       compare_wr;

    assign count_wr   = mtc0_en && (mtc0_addr == CP0_COUNT);
    assign compare_wr = mtc0_en && (mtc0_addr == CP0_COMPARE);

    cp0_timer u_cp0_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .count_wr   (count_wr),
        .compare_wr (compare_wr),
        .wdata      (mtc0_data),
        .count      (count),
        .compare    (compare),
        .timer_int  (timer_int)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register updates, exception commit last so it wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_im     <= '0;
            status_exl    <= 1'b1;    // come up in exception level.
            status_ie     <= 1'b0;
            cause_bd      <= 1'b0;
            cause_exccode <= '0;
            epc           <= '0;
            badvaddr      <= '0;
        end else begin
            if (mtc0_en && mtc0_addr == CP0_STATUS) begin
                status_im  <= mtc0_data[15:8];
                status_exl <= mtc0_data[1];
                status_ie  <= mtc0_data[0];
            end
            if (mtc0_en && mtc0_addr == CP0_EPC) begin
                epc <= mtc0_data;
            end
            if (upd.update) begin
                status_exl    <= 1'b1;
                cause_bd      <= upd.bd;
                cause_exccode <= upd.exccode;
                epc           <= upd.epc;
            end else if (upd.cls_exl) begin
                status_exl <= 1'b0;
            end
            if (upd.badvaddr_ena) begin
                badvaddr <= upd.badvaddr;
            end
        end
    end

    // software bits ip[1:0] read as zero.
    assign cause_ip = {hw_int[5] | timer_int, hw_int[4:0], 2'b00};
    assign int_req  = status_ie && !status_exl && |(cause_ip & status_im);

    always_comb begin
        case (mfc0_addr)
            CP0_BADVADDR: mfc0_data = badvaddr;
            CP0_COUNT:    mfc0_data = count;
            CP0_COMPARE:  mfc0_data = compare;
            CP0_STATUS:   mfc0_data = {16'b0, status_im, 6'b0, status_exl, status_ie};
            CP0_CAUSE:    mfc0_data = {cause_bd, 15'b0, cause_ip, 1'b0, cause_exccode, 2'b00};
            CP0_EPC:      mfc0_data = epc;
            default:      mfc0_data = '0;    // unimplemented.
        endcase
    end

endmodule

// ==== design/excp_top.sv ====
`timescale 1ns/1ps

module excp_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  excp_pkg::slot_info_t slot_1,
    input  excp_pkg::slot_info_t slot_2,
    input  logic [5:0]           hw_int,
    input  logic                 mtc0_en,
    input  excp_pkg::cp0_addr_t  mtc0_addr,
    input  excp_pkg::word_t      mtc0_data,
    input  excp_pkg::cp0_addr_t  mfc0_addr,
    output excp_pkg::word_t      mfc0_data,
    output logic                 redirect_en,
    output excp_pkg::word_t      redirect_pc,
    output logic                 flush
);
    import excp_pkg::*;

    logic     int_req;
    word_t    epc;
    cp0_upd_t upd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // resolver and cp0
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    exception_ctrl u_exception_ctrl (
        .slot_1      (slot_1),
        .slot_2      (slot_2),
        .int_req     (int_req),
        .epc         (epc),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .upd         (upd)
    );

    cp0_regs u_cp0_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd       (upd),
        .mtc0_en   (mtc0_en),
        .mtc0_addr (mtc0_addr),
        .mtc0_data (mtc0_data),
        .mfc0_addr (mfc0_addr),
        .mfc0_data (mfc0_data),
        .hw_int    (hw_int),
        .int_req   (int_req),
        .epc       (epc)
    );

endmodule

// ==== sim/excp_props.sv ====
`timescale 1ns/1ps

module excp_props (
    input logic                 clk,
    input logic                 rst_n,
    input excp_pkg::slot_info_t slot_1,
    input excp_pkg::slot_info_t slot_2,
    input logic                 int_req,
    input excp_pkg::cp0_upd_t   upd,
    input logic                 flush,
    input logic                 redirect_en,
    input logic                 status_exl
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // resolver and cp0 properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_redirect_on_event: assert property (@(posedge clk) disable iff (!rst_n)
        (flush == redirect_en) &&
        (redirect_en == (int_req || |slot_1.flags || |slot_2.flags)))
        else $error("redirect or flush does not match the pending events");

    a_eret_no_commit: assert property (@(posedge clk) disable iff (!rst_n)
        upd.cls_exl |=> !status_exl)    // a commit on eret would set exl.
        else $error("exl still set after an eret");

    a_exl_after_commit: assert property (@(posedge clk) disable iff (!rst_n)
        upd.update |=> status_exl)
        else $error("exl not set after an exception commit");

endmodule

bind excp_top excp_props u_excp_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .slot_1      (slot_1),
    .slot_2      (slot_2),
    .int_req     (int_req),
    .upd         (upd),
    .flush       (flush),
    .redirect_en (redirect_en),
    .status_exl  (u_cp0_regs.status_exl)
);

// ==== sim/excp_tb.sv ====
`timescale 1ns/1ps

module excp_tb;
    import excp_pkg::*;

    localparam int N_VEC   = 35;
    localparam int N_WORD  = 10;               // words per golden vector.
    localparam int MAX_CYC = N_VEC + 20;

    logic       clk;
    logic       rst_n;
    slot_info_t slot_1;
    slot_info_t slot_2;
    logic [5:0] hw_int;
    logic       mtc0_en;
    cp0_addr_t  mtc0_addr;
    word_t      mtc0_data;
    cp0_addr_t  mfc0_addr;
    word_t      mfc0_data;
    logic       redirect_en;
    word_t      redirect_pc;
    logic       flush;

    word_t golden [0:N_VEC*N_WORD-1];
    int    cycles = 0;

    excp_top u_excp_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot_1      (slot_1),
        .slot_2      (slot_2),
        .hw_int      (hw_int),
        .mtc0_en     (mtc0_en),
        .mtc0_addr   (mtc0_addr),
        .mtc0_data   (mtc0_data),
        .mfc0_addr   (mfc0_addr),
        .mfc0_data   (mfc0_data),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .flush       (flush)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("timeout, the vectors did not finish within %0d cycles", MAX_CYC);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apply_vector(input int v);
        logic [8:0] base;
        word_t      ctl;
        word_t      misc;
        base = 9'(v * N_WORD);
        ctl  = golden[base + 9'd4];
        misc = golden[base + 9'd5];
        slot_1.pc       <= golden[base];
        slot_1.badvaddr <= golden[base + 9'd1];
        slot_1.in_ds    <= ctl[16];
        slot_1.flags    <= excp_flags_t'(ctl[7:0]);
        slot_2.pc       <= golden[base + 9'd2];
        slot_2.badvaddr <= golden[base + 9'd3];
        slot_2.in_ds    <= ctl[20];
        slot_2.flags    <= excp_flags_t'(ctl[15:8]);
        hw_int          <= misc[5:0];
        mtc0_en         <= misc[8];
        mtc0_addr       <= misc[20:16];
        mfc0_addr       <= misc[28:24];
        mtc0_data       <= golden[base + 9'd6];
    endtask

    task automatic check_vector(input int v);
        logic [8:0] base;
        word_t      ctl;
        word_t      mask;
        base = 9'(v * N_WORD);
        ctl  = golden[base + 9'd4];
        mask = golden[base + 9'd9];
        check_bit("redirect_en", redirect_en, ctl[24]);
        check_bit("flush", flush, ctl[28]);
        if (ctl[24]) begin
            check_word("redirect_pc", redirect_pc, golden[base + 9'd7]);
        end
        check_word("mfc0_data", mfc0_data & mask, golden[base + 9'd8] & mask);
    endtask

    initial begin
        int v;
        rst_n     = 1'b0;
        slot_1    = '0;
        slot_2    = '0;
        hw_int    = '0;
        mtc0_en   = 1'b0;
        mtc0_addr = '0;
        mtc0_data = '0;
        mfc0_addr = '0;
        $readmemh("sim/excp_golden.hex", golden);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (v = 0; v < N_VEC; v++) begin
            @(posedge clk);
            apply_vector(v);
            @(negedge clk);      // outputs settled, well before the next edge.
            check_vector(v);
        end
        @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== mips_excp.f ====
design/excp_pkg.sv
design/exception_ctrl.sv
design/cp0_timer.sv
design/cp0_regs.sv
design/excp_top.sv
sim/excp_props.sv
sim/excp_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f mips_excp.f --top-module excp_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vexcp_tb); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== sim/excp_golden.hex ====
// s1_pc s1_badv s2_pc s2_badv ctl misc mtc0_data exp_redirect_pc exp_mfc0 mfc0_mask
// ctl: flush, redirect, s2_ds, s1_ds, s2_flags(2), s1_flags(2); misc: mfc0, mtc0, en, hw
00000000 00000000 00000000 00000000 00000000 0c000000 00000000 00000000 00000002 ffffffff
00400100 00000000 00000000 00000000 11000040 0e000000 00000000 bfc00380 00000000 ffffffff
00400200 00000000 00000000 00000000 11010001 0d000000 00000000 bfc00380 00000020 8000007c
00400300 00000000 00000000 00000000 11000002 0e000000 00000000 bfc00380 004001fc ffffffff
00400400 00000000 00000000 00000000 11000020 0d000000 00000000 bfc00380 00000030 8000007c
00000000 00000000 00000000 00000000 00000000 0d000000 00000000 00000000 00000024 8000007c
00400601 00000000 00000000 00000000 11000010 0e000000 00000000 bfc00380 00400400 ffffffff
00400700 10000003 00000000 00000000 11000008 08000000 00000000 bfc00380 00400601 ffffffff
00400800 20000006 00000000 00000000 11010004 08000000 00000000 bfc00380 10000003 ffffffff
00000000 00000000 00000000 00000000 00000000 08000000 00000000 00000000 20000006 ffffffff
00000000 00000000 00000000 00000000 00000000 0d000000 00000000 00000000 80000014 8000007c
00401100 00000000 00402000 00000000 11004053 0d000000 00000000 bfc00380 80000014 8000007c
00401200 00000000 00000000 00000000 11000023 0d000000 00000000 bfc00380 00000010 8000007c
00401300 00000000 00000000 00000000 110000e8 0d000000 00000000 bfc00380 00000028 8000007c
00401400 00000000 00000000 00000000 1100008c 0d000000 00000000 00401300 00000020 8000007c
00000000 00000000 00402500 00000000 11100200 0c000000 00000000 bfc00380 00000000 ffffffff
00401600 30000008 00402600 00000000 11001004 0d000000 00000000 bfc00380 80000030 8000007c
00000000 00000000 00000000 00000000 00000000 0d000000 00000000 00000000 00000014 8000007c
00000000 00000000 00000000 00000000 00000000 08000000 00000000 00000000 30000008 ffffffff
00000000 00000000 00000000 00000000 00000000 0e0e0100 00123450 00000000 00401600 ffffffff
00402000 00000000 00000000 00000000 11000080 0e000000 00000000 00123450 00123450 ffffffff
00000000 00000000 00000000 00000000 00000000 0c000000 00000000 00000000 00000000 ffffffff
00000000 00000000 00000000 00000000 00000000 0d000000 00000000 00000000 00000014 8000007c
00000000 00000000 00000000 00000000 00000000 0c0c0100 00000403 00000000 00000000 ffffffff
00000000 00000000 00000000 00000000 00000000 0c000001 00000000 00000000 00000403 ffffffff
00000000 00000000 00000000 00000000 00000000 0c0c0101 00000401 00000000 00000403 ffffffff
00402600 00000000 00000000 00000000 11000000 0d000001 00000000 bfc00380 00000014 8000007c
00000000 00000000 00000000 00000000 00000000 0d000001 00000000 00000000 00000000 8000007c
00000000 00000000 00000000 00000000 00000000 090b0100 00000010 00000000 0000000e ffffffff
00000000 00000000 00000000 00000000 00000000 0b0c0100 00008001 00000000 00000010 ffffffff
00000000 00000000 00000000 00000000 00000000 09000000 00000000 00000000 0000000f ffffffff
00000000 00000000 00000000 00000000 00000000 09000000 00000000 00000000 00000010 ffffffff
00403200 00000000 00000000 00000000 11000000 0d000000 00000000 bfc00380 00008000 ffffffff
00000000 00000000 00000000 00000000 00000000 0d0b0100 00000100 00000000 00008000 ffffffff
00000000 00000000 00000000 00000000 00000000 0d000000 00000000 00000000 00000000 ffffffff
